//--- Makefile
VERILATOR   ?= verilator
TOP         ?= ifu_tb
LINT_TOP    ?= ifu
FILELIST    ?= build.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS  ?= --lint-only --timing -Wall
ERROR_LIMIT ?= 1000
PASS_TEXT   ?= TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
+incdir+include
verilog/ifu_pkg.sv
verilog/ifu_fetch_ctl.sv
verilog/ifu_bp.sv
verilog/ifu_aligner.sv
verilog/ifu.sv
tests/ifu_properties.sv
tests/ifu_clk_gen.sv
tests/ifu_tb.sv

//--- include/ifu_consts.svh
`ifndef IFU_CONSTS_SVH
`define IFU_CONSTS_SVH

// **************************************************
// Fetch address
// **************************************************

// Word address of the first fetch after reset
// Byte address 0x80
`define IFU_RESET_VECTOR 30'h0000_0020

// **************************************************
// Branch target buffer
// **************************************************

// Direct mapped, one entry per index value
`define IFU_BTB_ENTRIES 16

// Low word address bits that pick the entry, 2**bits entries
`define IFU_BTB_INDEX_BITS 4

// **************************************************
// Fetch buffer
// **************************************************

// Words queued between memory and decode
`define IFU_FB_DEPTH 4

`endif

//--- tests/ifu_clk_gen.sv
`timescale 1ns/1ps

module ifu_clk_gen (
   output logic clk,    // 4 ns period
   output logic arst_n  // Low for the first two cycles
);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      arst_n = 1'b0;
      repeat (2) @(posedge clk);
      #1 arst_n = 1'b1;   // Released just after the edge
   end

endmodule

//--- tests/ifu_properties.sv
`timescale 1ns/1ps

module ifu_properties (
   input logic                 clk,
   input logic                 arst_n,
   input logic                 ic_rd_en,
   input logic                 exu_flush_final,
   input logic                 dec_ready,
   input logic                 ifu_i0_valid,
   input ifu_pkg::instr_t      ifu_i0_instr,
   input ifu_pkg::fetch_addr_t ifu_i0_pc,
   input logic                 ifu_i0_pred_taken,
   input ifu_pkg::fetch_addr_t ifu_i0_pred_target
);

   int fail_count = 0;   // Assertion failures so far

   // Head entry holds while decode stalls
   held_while_stalled : assert property (@(posedge clk) disable iff (!arst_n)
      (ifu_i0_valid && !dec_ready && !exu_flush_final) |=>
         (ifu_i0_valid && $stable(ifu_i0_instr) && $stable(ifu_i0_pc)
          && $stable(ifu_i0_pred_taken) && $stable(ifu_i0_pred_target)))
   else begin
      $error("decode outputs changed while decode was stalled");
      fail_count++;
   end

   // Buffer is empty the cycle after a flush
   empty_after_flush : assert property (@(posedge clk) disable iff (!arst_n)
      exu_flush_final |=> !ifu_i0_valid)
   else begin
      $error("instruction valid in the cycle after a flush");
      fail_count++;
   end

   // No memory read while in reset
   no_read_in_reset : assert property (@(posedge clk) !arst_n |-> !ic_rd_en)
   else begin
      $error("memory read issued during reset");
      fail_count++;
   end

endmodule

bind ifu ifu_properties u_props (
   .clk                (clk),
   .arst_n             (arst_n),
   .ic_rd_en           (ic_rd_en),
   .exu_flush_final    (exu_flush_final),
   .dec_ready          (dec_ready),
   .ifu_i0_valid       (ifu_i0_valid),
   .ifu_i0_instr       (ifu_i0_instr),
   .ifu_i0_pc          (ifu_i0_pc),
   .ifu_i0_pred_taken  (ifu_i0_pred_taken),
   .ifu_i0_pred_target (ifu_i0_pred_target)
);

//--- tests/ifu_tb.sv
`timescale 1ns/1ps
`include "ifu_consts.svh"

module ifu_tb;

   localparam logic [31:0] mem_salt = 32'h5a3c_91e7;   // Mixed into every memory address

   logic clk, arst_n;
   logic ic_rd_en, exu_flush_final, dec_tlu_flush_noredir, dec_tlu_bpred_disable;
   logic exu_mp_valid, exu_mp_taken, dec_ready, ifu_i0_valid, ifu_i0_pred_taken;
   ifu_pkg::instr_t      ic_rd_data, ifu_i0_instr;
   ifu_pkg::fetch_addr_t ic_rw_addr, exu_flush_path_final, exu_mp_addr, exu_mp_target;
   ifu_pkg::fetch_addr_t ifu_i0_pc, ifu_i0_pred_target;

   integer seed = 32'h11f6;              // Stimulus seed
   string  test_name;
   int     errors, test_errors, tests_run, tests_bad, consumed, taken_seen, start_count;
   logic   ready_rand;                   // Random dec_ready when set
   logic   mem_req;                      // Read seen in the current cycle
   ifu_pkg::fetch_addr_t mem_addr;

   // **************************************************
   // Reference model state
   // **************************************************

   ifu_pkg::fetch_addr_t exp_pc, last_pc;                // Next expected pc, last consumed
   logic                 fetch_idle;                     // Set by a flush without redirect
   logic                 m_valid  [`IFU_BTB_ENTRIES];
   ifu_pkg::btb_tag_t    m_tag    [`IFU_BTB_ENTRIES];
   ifu_pkg::fetch_addr_t m_target [`IFU_BTB_ENTRIES];

   ifu_clk_gen u_clk_gen (.clk(clk), .arst_n(arst_n));
   ifu         u_ifu (.*);

   // Fixed random word per address
   function automatic ifu_pkg::instr_t mem_word(input ifu_pkg::fetch_addr_t addr);
      integer s;
      integer w;
      s = mem_salt ^ {addr, 2'b00};
      w = $random(s);
      w = $random(s);                    // Second draw spreads neighbouring addresses
      return w;
   endfunction

   function automatic logic model_hit(input ifu_pkg::fetch_addr_t pc);
      ifu_pkg::btb_index_t idx;
      idx = pc[`IFU_BTB_INDEX_BITS-1:0];
      return !dec_tlu_bpred_disable && m_valid[idx]
             && (m_tag[idx] == pc[29:`IFU_BTB_INDEX_BITS]);
   endfunction

   function automatic ifu_pkg::fetch_addr_t rand_path();
      return `IFU_RESET_VECTOR + 30'($unsigned($random(seed)) % 64);   // 64 word window
   endfunction

   task automatic report_mismatch(input string what, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("ERROR %s %s: expected %h actual %h", test_name, what, expected, actual);
      errors++;
   endtask

   // One instruction taken by decode, compared with the model stream
   task automatic check_consumed();
      ifu_pkg::btb_index_t idx;
      logic                hit;
      idx = exp_pc[`IFU_BTB_INDEX_BITS-1:0];
      hit = model_hit(exp_pc);
      assert (!fetch_idle) else begin
         $display("ERROR %s: pc %h reached decode while fetch was idle", test_name, ifu_i0_pc);
         errors++;
      end
      assert (ifu_i0_pc == exp_pc) else report_mismatch("pc", exp_pc, ifu_i0_pc);
      assert (ifu_i0_instr == mem_word(exp_pc))
         else report_mismatch("instr", mem_word(exp_pc), ifu_i0_instr);
      assert (ifu_i0_pred_taken == hit)
         else report_mismatch("pred_taken", hit, ifu_i0_pred_taken);
      assert (!hit || ifu_i0_pred_target == m_target[idx])
         else report_mismatch("pred_target", m_target[idx], ifu_i0_pred_target);
      consumed++;
      taken_seen += int'(ifu_i0_pred_taken);
      last_pc = ifu_i0_pc;
      exp_pc  = hit ? m_target[idx] : exp_pc + 30'd1;   // Taken branch jumps to the target
   endtask

   // **************************************************
   // Memory model and decode monitor
   // **************************************************

   always begin
      @(negedge clk);
      mem_req  = ic_rd_en;               // Request is stable mid-cycle
      mem_addr = ic_rw_addr;
      @(posedge clk);
      #1;
      if (mem_req) begin
         ic_rd_data = mem_word(mem_addr);   // Data during the cycle after the read
      end
   end

   always @(negedge clk) begin
      if (arst_n && exu_flush_final) begin
         exp_pc     = exu_flush_path_final;   // Stream restarts at the flush path
         fetch_idle = dec_tlu_flush_noredir;
      end else if (arst_n && ifu_i0_valid && dec_ready) begin
         check_consumed();
      end
   end

   // **************************************************
   // Stimulus helpers
   // **************************************************

   task automatic run_cycle();
      @(posedge clk);
      #1;
      exu_flush_final       = 1'b0;      // Pulses last one cycle
      dec_tlu_flush_noredir = 1'b0;
      exu_mp_valid          = 1'b0;
      dec_ready             = ready_rand ? 1'($random(seed)) : 1'b1;
   endtask

   task automatic send_flush(input ifu_pkg::fetch_addr_t path, input logic noredir);
      run_cycle();
      exu_flush_final       = 1'b1;
      exu_flush_path_final  = path;
      dec_tlu_flush_noredir = noredir;
   endtask

   task automatic go_idle();
      send_flush(rand_path(), 1'b1);
      run_cycle();
      run_cycle();
   endtask

   // BTB update while fetch is idle, model follows the same rule
   task automatic write_btb(input ifu_pkg::fetch_addr_t addr,
                            input ifu_pkg::fetch_addr_t target, input logic taken);
      ifu_pkg::btb_index_t idx;
      idx = addr[`IFU_BTB_INDEX_BITS-1:0];
      run_cycle();
      exu_mp_valid  = 1'b1;
      exu_mp_addr   = addr;
      exu_mp_target = target;
      exu_mp_taken  = taken;
      if (taken) begin
         m_valid[idx]  = 1'b1;
         m_tag[idx]    = addr[29:`IFU_BTB_INDEX_BITS];
         m_target[idx] = target;
      end else if (m_valid[idx] && m_tag[idx] == addr[29:`IFU_BTB_INDEX_BITS]) begin
         m_valid[idx] = 1'b0;            // Only the matching branch loses its entry
      end
      run_cycle();
   endtask

   task automatic wait_consumed(input int n, input int limit);
      int target;
      int cycles;
      target = consumed + n;
      cycles = 0;
      while (consumed < target && cycles < limit) begin
         run_cycle();
         cycles++;
      end
      assert (consumed >= target) else begin
         $display("ERROR %s: timed out after %0d cycles waiting for %0d instructions",
                  test_name, limit, n);
         errors++;
      end
   endtask

   task automatic begin_test(input string name);
      test_name   = name;
      test_errors = errors;
      start_count = consumed;
   endtask

   task automatic end_test();
      tests_run++;
      if (errors != test_errors) begin
         tests_bad++;
      end
      $display("%-14s %0d errors, %0d instructions", test_name, errors - test_errors,
               consumed - start_count);
   endtask

   // **************************************************
   // Test sequence
   // **************************************************

   initial begin
      int                   n;
      int                   t0;
      ifu_pkg::fetch_addr_t path;
      ifu_pkg::fetch_addr_t prev;
      ic_rd_data            = '0;
      exu_flush_final       = 1'b0;
      exu_flush_path_final  = '0;
      dec_tlu_flush_noredir = 1'b0;
      dec_tlu_bpred_disable = 1'b0;
      exu_mp_valid          = 1'b0;
      exu_mp_addr           = '0;
      exu_mp_target         = '0;
      exu_mp_taken          = 1'b0;
      dec_ready             = 1'b0;
      ready_rand            = 1'b0;
      exp_pc                = `IFU_RESET_VECTOR;
      fetch_idle            = 1'b0;
      for (int i = 0; i < `IFU_BTB_ENTRIES; i++) begin
         m_valid[i] = 1'b0;
      end
      n = 0;
      while (!arst_n && n < 10) begin
         @(posedge clk);
         n++;
      end
      assert (arst_n) else begin
         $display("ERROR: reset was still asserted after %0d cycles", n);
         errors++;
      end

      begin_test("reset_vector");
      wait_consumed(1, 50);
      assert (last_pc == `IFU_RESET_VECTOR)
         else report_mismatch("first pc", `IFU_RESET_VECTOR, last_pc);
      end_test();

      begin_test("sequential");
      prev = last_pc;
      t0   = taken_seen;
      wait_consumed(24, 200);
      assert (last_pc == prev + 30'd24) else report_mismatch("last pc", prev + 30'd24, last_pc);
      assert (taken_seen == t0) else report_mismatch("taken count", t0, taken_seen);
      end_test();

      begin_test("prediction");
      go_idle();
      write_btb(`IFU_RESET_VECTOR + 30'd6, `IFU_RESET_VECTOR + 30'd40, 1'b1);
      t0 = taken_seen;
      send_flush(`IFU_RESET_VECTOR, 1'b0);
      wait_consumed(12, 100);            // Seven up to the branch, five from the target
      assert (taken_seen == t0 + 1) else report_mismatch("taken count", t0 + 1, taken_seen);
      assert (last_pc == `IFU_RESET_VECTOR + 30'd44)
         else report_mismatch("last pc", `IFU_RESET_VECTOR + 30'd44, last_pc);
      go_idle();
      write_btb(`IFU_RESET_VECTOR + 30'd6, '0, 1'b0);
      t0 = taken_seen;
      send_flush(`IFU_RESET_VECTOR, 1'b0);
      wait_consumed(12, 100);
      assert (taken_seen == t0) else report_mismatch("taken count", t0, taken_seen);
      assert (last_pc == `IFU_RESET_VECTOR + 30'd11)
         else report_mismatch("last pc", `IFU_RESET_VECTOR + 30'd11, last_pc);
      end_test();

      begin_test("random_flush");
      ready_rand = 1'b1;
      repeat (12) begin
         repeat ($unsigned($random(seed)) % 16) run_cycle();
         if (($random(seed) & 3) == 0) begin
            send_flush(rand_path(), 1'b1);
            n = consumed;
            repeat (20) run_cycle();
            assert (consumed == n) else begin
               $display("ERROR %s: decode got an instruction after a flush without redirect",
                        test_name);
               errors++;
            end
         end
         path = rand_path();
         send_flush(path, 1'b0);
         wait_consumed(1, 100);
         assert (last_pc == path) else report_mismatch("restart pc", path, last_pc);
      end
      end_test();

      begin_test("back_pressure");
      wait_consumed(80, 800);
      end_test();

      begin_test("bpred_disable");
      ready_rand = 1'b0;
      go_idle();
      write_btb(`IFU_RESET_VECTOR + 30'd3, `IFU_RESET_VECTOR + 30'd50, 1'b1);
      dec_tlu_bpred_disable = 1'b1;
      t0 = taken_seen;
      send_flush(`IFU_RESET_VECTOR, 1'b0);
      wait_consumed(10, 100);
      assert (taken_seen == t0) else report_mismatch("taken count", t0, taken_seen);
      assert (last_pc == `IFU_RESET_VECTOR + 30'd9)
         else report_mismatch("last pc", `IFU_RESET_VECTOR + 30'd9, last_pc);
      end_test();

      $display("%0d tests, %0d with errors, %0d instructions, %0d errors, %0d property failures",
               tests_run, tests_bad, consumed, errors, u_ifu.u_props.fail_count);
      if (errors == 0 && u_ifu.u_props.fail_count == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- verilog/ifu.sv
`timescale 1ns/1ps
`include "ifu_consts.svh"

module ifu (
   input  logic                 clk,
   input  logic                 arst_n,

   // Memory read port, data one cycle after the request
   output logic                 ic_rd_en,
   output ifu_pkg::fetch_addr_t ic_rw_addr,
   input  ifu_pkg::instr_t      ic_rd_data,

   // Execute and control
   input  logic                 exu_flush_final,       // Flush pulse
   input  ifu_pkg::fetch_addr_t exu_flush_path_final,  // Flush target
   input  logic                 dec_tlu_flush_noredir, // Qualified by the flush
   input  logic                 dec_tlu_bpred_disable, // Level
   input  logic                 exu_mp_valid,          // BTB update pulse
   input  ifu_pkg::fetch_addr_t exu_mp_addr,
   input  ifu_pkg::fetch_addr_t exu_mp_target,
   input  logic                 exu_mp_taken,

   // Decode
   input  logic                 dec_ready,             // Back-pressure
   output logic                 ifu_i0_valid,
   output ifu_pkg::instr_t      ifu_i0_instr,
   output ifu_pkg::fetch_addr_t ifu_i0_pc,
   output logic                 ifu_i0_pred_taken,
   output ifu_pkg::fetch_addr_t ifu_i0_pred_target
);

   // **************************************************
   // F2 and buffer status
   // **************************************************

   logic                                fetch_valid_f2; // Returning word is wanted
   ifu_pkg::fetch_addr_t                fetch_addr_f2;  // Its pc
   logic                                bp_hit_f2;      // BTB taken for that word
   ifu_pkg::fetch_addr_t                bp_target_f2;   // BTB target
   logic [$clog2(`IFU_FB_DEPTH+1)-1:0]  fb_space;       // Free buffer slots

   // Fetch address FSM and memory request
   ifu_fetch_ctl u_fetch_ctl (
      .*
   );

   // BTB looks up the same address as the memory read
   ifu_bp u_bp (
      .*,
      .lookup_addr (ic_rw_addr)
   );

   // Fetch buffer toward decode
   ifu_aligner u_aligner (
      .*
   );

endmodule

//--- verilog/ifu_aligner.sv
`timescale 1ns/1ps
`include "ifu_consts.svh"

module ifu_aligner (
   input  logic                               clk,
   input  logic                               arst_n,
   input  logic                               exu_flush_final,    // Empties the buffer
   input  logic                               fetch_valid_f2,     // Word from memory is wanted
   input  ifu_pkg::fetch_addr_t               fetch_addr_f2,      // Its pc
   input  ifu_pkg::instr_t                    ic_rd_data,         // Word from memory
   input  logic                               bp_hit_f2,          // Predicted taken
   input  ifu_pkg::fetch_addr_t               bp_target_f2,       // Predicted target
   input  logic                               dec_ready,          // Decode takes the head
   output logic [$clog2(`IFU_FB_DEPTH+1)-1:0] fb_space,           // Free slots
   output logic                               ifu_i0_valid,
   output ifu_pkg::instr_t                    ifu_i0_instr,
   output ifu_pkg::fetch_addr_t               ifu_i0_pc,
   output logic                               ifu_i0_pred_taken,
   output ifu_pkg::fetch_addr_t               ifu_i0_pred_target
);

   localparam int fb_idx_w = $clog2(`IFU_FB_DEPTH);     // Slot index width
   localparam int fb_cnt_w = $clog2(`IFU_FB_DEPTH + 1); // Occupancy width

   // **************************************************
   // Buffer slots
   // **************************************************

   ifu_pkg::instr_t      fb_instr       [`IFU_FB_DEPTH];
   ifu_pkg::fetch_addr_t fb_pc          [`IFU_FB_DEPTH];
   logic                 fb_pred_taken  [`IFU_FB_DEPTH];
   ifu_pkg::fetch_addr_t fb_pred_target [`IFU_FB_DEPTH];

   logic [fb_idx_w-1:0] wr_ptr;   // Next slot to fill
   logic [fb_idx_w-1:0] rd_ptr;   // Head toward decode
   logic [fb_cnt_w-1:0] fb_count; // Occupied slots
   logic                push;
   logic                pop;

   // Wraps for any depth, not only powers of two
   function automatic logic [fb_idx_w-1:0] ptr_inc(input logic [fb_idx_w-1:0] ptr);
      if (ptr == fb_idx_w'(`IFU_FB_DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign push = fetch_valid_f2 & ~exu_flush_final;  // Flush kills the F2 word too
   assign pop  = ifu_i0_valid & dec_ready;           // Consumed this cycle

   // **************************************************
   // Pointers and count
   // **************************************************

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         fb_count <= '0;
      end else if (exu_flush_final) begin
         wr_ptr   <= '0;                             // Drop every queued word
         rd_ptr   <= '0;
         fb_count <= '0;
      end else begin
         if (push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         fb_count <= fb_count + fb_cnt_w'(push) - fb_cnt_w'(pop);
      end
   end

   // Payload, written once per landed word
   always_ff @(posedge clk) begin
      if (push) begin
         fb_instr[wr_ptr]       <= ic_rd_data;
         fb_pc[wr_ptr]          <= fetch_addr_f2;
         fb_pred_taken[wr_ptr]  <= bp_hit_f2;
         fb_pred_target[wr_ptr] <= bp_target_f2;
      end
   end

   // **************************************************
   // Decode side
   // **************************************************

   assign fb_space           = fb_cnt_w'(`IFU_FB_DEPTH) - fb_count;
   assign ifu_i0_valid       = (fb_count != '0);
   assign ifu_i0_instr       = fb_instr[rd_ptr];       // Head holds while not consumed
   assign ifu_i0_pc          = fb_pc[rd_ptr];
   assign ifu_i0_pred_taken  = fb_pred_taken[rd_ptr];
   assign ifu_i0_pred_target = fb_pred_target[rd_ptr];

endmodule

//--- verilog/ifu_bp.sv
`timescale 1ns/1ps
`include "ifu_consts.svh"

module ifu_bp (
   input  logic                 clk,
   input  logic                 arst_n,
   input  ifu_pkg::fetch_addr_t lookup_addr,           // F1 fetch address
   input  logic                 dec_tlu_bpred_disable, // Level, masks all hits
   input  logic                 exu_mp_valid,          // Update pulse from execute
   input  ifu_pkg::fetch_addr_t exu_mp_addr,           // Branch word address
   input  ifu_pkg::fetch_addr_t exu_mp_target,         // Resolved target
   input  logic                 exu_mp_taken,          // Resolved direction
   output logic                 bp_hit_f2,             // Predicted taken in F2
   output ifu_pkg::fetch_addr_t bp_target_f2           // Predicted target in F2
);

   // **************************************************
   // Storage
   // **************************************************

   logic [`IFU_BTB_ENTRIES-1:0] btb_valid;                      // One valid bit per entry
   ifu_pkg::btb_tag_t           btb_tag    [`IFU_BTB_ENTRIES]; // Upper branch address bits
   ifu_pkg::fetch_addr_t        btb_target [`IFU_BTB_ENTRIES]; // Taken target

   ifu_pkg::fetch_addr_t lookup_addr_f2; // Lookup address one cycle later
   ifu_pkg::btb_index_t  rd_index_f2;
   ifu_pkg::btb_tag_t    rd_tag_f2;
   ifu_pkg::btb_index_t  wr_index;
   ifu_pkg::btb_tag_t    wr_tag;
   logic                 wr_tag_match;   // Update hits a live entry
   logic                 rd_tag_match;

   // **************************************************
   // Address split
   // **************************************************

   assign rd_index_f2 = lookup_addr_f2[`IFU_BTB_INDEX_BITS-1:0];
   assign rd_tag_f2   = lookup_addr_f2[29:`IFU_BTB_INDEX_BITS];
   assign wr_index    = exu_mp_addr[`IFU_BTB_INDEX_BITS-1:0];
   assign wr_tag      = exu_mp_addr[29:`IFU_BTB_INDEX_BITS];

   assign wr_tag_match = btb_valid[wr_index] & (btb_tag[wr_index] == wr_tag);
   assign rd_tag_match = btb_valid[rd_index_f2] & (btb_tag[rd_index_f2] == rd_tag_f2);

   // **************************************************
   // Lookup, F1 address registered into F2
   // **************************************************

   always_ff @(posedge clk) begin
      lookup_addr_f2 <= lookup_addr;                            // Follows the memory read
   end

   assign bp_hit_f2    = rd_tag_match & ~dec_tlu_bpred_disable; // Disable kills every hit
   assign bp_target_f2 = btb_target[rd_index_f2];

   // **************************************************
   // Update from execute
   // **************************************************

   // Valid bits, set on taken, dropped on not taken with a tag match
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         btb_valid <= '0;
      end else if (exu_mp_valid) begin
         if (exu_mp_taken) begin
            btb_valid[wr_index] <= 1'b1;
         end else if (wr_tag_match) begin
            btb_valid[wr_index] <= 1'b0;                        // Other branch keeps its slot
         end
      end
   end

   // Tag and target only change on a taken update
   always_ff @(posedge clk) begin
      if (exu_mp_valid & exu_mp_taken) begin
         btb_tag[wr_index]    <= wr_tag;
         btb_target[wr_index] <= exu_mp_target;
      end
   end

endmodule

//--- verilog/ifu_fetch_ctl.sv
`timescale 1ns/1ps
`include "ifu_consts.svh"

module ifu_fetch_ctl (
   input  logic                                 clk,
   input  logic                                 arst_n,
   input  logic                                 exu_flush_final,       // Flush pulse from execute
   input  ifu_pkg::fetch_addr_t                 exu_flush_path_final,  // Restart address
   input  logic                                 dec_tlu_flush_noredir, // Go idle on this flush
   input  logic                                 bp_hit_f2,             // BTB hit for the F2 word
   input  ifu_pkg::fetch_addr_t                 bp_target_f2,          // Predicted target
   input  logic [$clog2(`IFU_FB_DEPTH+1)-1:0]   fb_space,              // Free fetch buffer slots
   output logic                                 ic_rd_en,              // Memory read request
   output ifu_pkg::fetch_addr_t                 ic_rw_addr,            // Memory read address
   output logic                                 fetch_valid_f2,        // Returning word is wanted
   output ifu_pkg::fetch_addr_t                 fetch_addr_f2          // Address of returning word
);

   localparam int fb_cnt_w = $clog2(`IFU_FB_DEPTH + 1); // Width of the slot counts

   ifu_pkg::fetch_state_t state;          // FSM state
   ifu_pkg::fetch_state_t state_nxt;
   ifu_pkg::fetch_addr_t  fetch_addr;     // F1 address, next word to read
   ifu_pkg::fetch_addr_t  fetch_addr_nxt;
   logic                  fetch_armed;    // Set one cycle after reset release
   logic [fb_cnt_w-1:0]   inflight;       // Reads whose word has not landed yet
   logic                  taken_f2;       // F2 word predicted taken

   // **************************************************
   // F1 request
   // **************************************************

   assign inflight   = fb_cnt_w'(fetch_valid_f2);                   // 0 or 1 read in F2
   assign taken_f2   = fetch_valid_f2 & bp_hit_f2;                  // Hit already masked by disable
   assign ic_rw_addr = fetch_addr;                                  // Also drives the BTB lookup

   // Only read when the word is sure to find a slot
   assign ic_rd_en = fetch_armed & (state == ifu_pkg::FETCH_RUN) & (fb_space > inflight);

   // Next address and state, flush has priority over prediction
   always_comb begin
      state_nxt      = state;
      fetch_addr_nxt = fetch_addr;
      if (exu_flush_final) begin
         state_nxt      = dec_tlu_flush_noredir ? ifu_pkg::FETCH_IDLE : ifu_pkg::FETCH_RUN;
         fetch_addr_nxt = exu_flush_path_final;                     // Restart point
      end else if (taken_f2) begin
         fetch_addr_nxt = bp_target_f2;                             // Drop the sequential read
      end else if (ic_rd_en) begin
         fetch_addr_nxt = fetch_addr + 30'd1;                       // One word per read
      end
   end

   // **************************************************
   // State and F2 control
   // **************************************************

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state          <= ifu_pkg::FETCH_RUN;
         fetch_addr     <= `IFU_RESET_VECTOR;
         fetch_armed    <= 1'b0;
         fetch_valid_f2 <= 1'b0;
      end else begin
         state          <= state_nxt;
         fetch_addr     <= fetch_addr_nxt;
         fetch_armed    <= 1'b1;
         // Read issued now is killed by a flush or a taken redirect
         fetch_valid_f2 <= ic_rd_en & ~exu_flush_final & ~taken_f2;
      end
   end

   // F2 address follows the read it belongs to
   always_ff @(posedge clk) begin
      if (ic_rd_en) begin
         fetch_addr_f2 <= fetch_addr;
      end
   end

endmodule

//--- verilog/ifu_pkg.sv
`include "ifu_consts.svh"

package ifu_pkg;

   // **************************************************
   // Address and data
   // **************************************************

   // Word address, byte address bits 31:2
   typedef logic [29:0] fetch_addr_t;

   // One 32-bit instruction word
   typedef logic [31:0] instr_t;

   // **************************************************
   // Branch target buffer fields
   // **************************************************

   // Low fetch address bits, select the BTB entry
   typedef logic [`IFU_BTB_INDEX_BITS-1:0] btb_index_t;

   // Remaining upper address bits, kept for the hit compare
   typedef logic [29-`IFU_BTB_INDEX_BITS:0] btb_tag_t;

   // **************************************************
   // Fetch control FSM
   // **************************************************

   typedef enum logic {
      FETCH_IDLE, // Stopped after a flush without redirect
      FETCH_RUN   // Issuing reads
   } fetch_state_t;

endpackage
